//--- dma_axil_slave.sv
`timescale 1ns/1ps

module dma_axil_slave
	import dma_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [31:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [31:0] s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [31:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	output rf_wr_t rf_wr,
	output rf_rd_t rf_rd,
	input logic [NUM_CH-1:0][3:0][31:0] rd_data,
	input logic [NUM_CH-1:0] irq_stat
);

	logic wr_hs;
	logic rd_hs;
	logic wr_go;
	logic wr_we_q;
	ch_t wr_ch_q;
	logic [1:0] wr_idx_q;
	logic [31:0] wr_data_q;
	logic rd_ok;
	logic rd_glob;
	logic [31:0] rd_word;

	// Channel blocks start at 0x20, four words each
	function automatic logic blk_ok(input logic [31:0] a);
		logic [2:0] blk;
		blk = a[7:5];
		return (a[31:8] == '0) && !a[4] && (blk != 3'd0) && (blk <= 3'(NUM_CH));
	endfunction

	function automatic ch_t blk_ch(input logic [31:0] a);
		return CH_W'(a[7:5] - 3'd1);
	endfunction

	assign wr_hs = s_awready && s_awvalid && s_wvalid;
	assign rd_hs = s_arready && s_arvalid;
	assign wr_go = s_awvalid && s_wvalid && !s_awready && !s_bvalid;
	assign s_bresp = 2'b00;
	assign s_rresp = 2'b00;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			s_awready <= 1'b0;
			s_wready <= 1'b0;
			s_bvalid <= 1'b0;
			wr_we_q <= 1'b0;
			s_arready <= 1'b0;
			s_rvalid <= 1'b0;
		end
		else
		begin
			s_awready <= wr_go;
			s_wready <= wr_go;
			// Narrow writes are dropped
			wr_we_q <= wr_hs && blk_ok(s_awaddr) && (s_wstrb == 4'hf);
			if (wr_hs)
				s_bvalid <= 1'b1;
			else if (s_bready)
				s_bvalid <= 1'b0;
			s_arready <= s_arvalid && !s_arready && !s_rvalid;
			if (rd_hs)
				s_rvalid <= 1'b1;
			else if (s_rready)
				s_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_hs)
		begin
			wr_ch_q <= blk_ch(s_awaddr);
			wr_idx_q <= s_awaddr[3:2];
			wr_data_q <= s_wdata;
		end
		if (rd_hs)
			s_rdata <= rd_word;
	end

	assign rd_ok = blk_ok(s_araddr);
	assign rd_glob = (s_araddr[31:2] == '0);

	always_comb
	begin
		rf_wr.we = wr_we_q;
		rf_wr.ch = wr_ch_q;
		rf_wr.idx = wr_idx_q;
		rf_wr.data = wr_data_q;
		rf_rd.re = rd_hs && rd_ok;
		rf_rd.ch = blk_ch(s_araddr);
		rf_rd.idx = s_araddr[3:2];
	end

	// Global word carries the per-channel irq lines
	always_comb
	begin
		rd_word = '0;
		if (rd_glob)
			rd_word[NUM_CH-1:0] = irq_stat;
		else if (rd_ok)
			rd_word = rd_data[blk_ch(s_araddr)][s_araddr[3:2]];
	end

	assert property (@(posedge clk) disable iff (!rst)
		$rose(s_bvalid) |-> $past(s_awvalid && s_awready && s_wvalid && s_wready));

endmodule

//--- dma_ch_rf.sv
`timescale 1ns/1ps

module dma_ch_rf
	import dma_pkg::*;
#(
	parameter int CH_NO = 0,
	parameter bit HAVE_ARS = 1'b1
)
(
	input logic clk,
	input logic rst,
	input rf_wr_t rf_wr,
	input rf_rd_t rf_rd,
	input de_upd_t de_upd,
	input de_stat_t de_stat,
	output ch_regs_t regs,
	output logic [3:0][31:0] rd_words,
	output logic stop,
	output logic irq
);

	localparam ch_t MY_CH = CH_W'(CH_NO);

	logic wr_me;
	logic csr_we;
	logic txsz_we;
	logic adr0_we;
	logic adr1_we;
	logic csr_re;
	logic upd_me;
	logic done_ev;
	logic err_ev;
	logic ars_on;
	logic done_we;
	logic en_q;
	logic ars_q;
	logic [2:0] pri_q;
	logic [1:0] imask_q;
	logic [1:0] isrc_q;
	logic done_q;
	logic err_q;
	logic busy_q;
	logic rl_q;
	logic [11:0] size_q;
	logic [31:0] src_q;
	logic [31:0] dst_q;
	logic [11:0] sh_size;
	logic [31:0] sh_src;
	logic [31:0] sh_dst;
	logic [31:0] csr_word;

	assign wr_me = rf_wr.we && (rf_wr.ch == MY_CH);
	assign csr_we = wr_me && (rf_wr.idx == REG_CSR);
	assign txsz_we = wr_me && (rf_wr.idx == REG_TXSZ);
	assign adr0_we = wr_me && (rf_wr.idx == REG_ADR0);
	assign adr1_we = wr_me && (rf_wr.idx == REG_ADR1);
	assign csr_re = rf_rd.re && (rf_rd.ch == MY_CH) && (rf_rd.idx == REG_CSR);

	assign upd_me = de_upd.upd && (de_upd.ch == MY_CH);
	assign done_ev = de_stat.done && (de_stat.ch == MY_CH);
	assign err_ev = de_stat.err && (de_stat.ch == MY_CH);
	assign ars_on = HAVE_ARS && ars_q;
	// With ARS the done is swallowed and the block restarts
	assign done_we = done_ev && !ars_on;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			en_q <= 1'b0;
			ars_q <= 1'b0;
			pri_q <= '0;
			imask_q <= '0;
			isrc_q <= '0;
			done_q <= 1'b0;
			err_q <= 1'b0;
			busy_q <= 1'b0;
			rl_q <= 1'b0;
			stop <= 1'b0;
		end
		else
		begin
			stop <= csr_we && rf_wr.data[CSR_STOP];
			busy_q <= de_stat.busy && (de_stat.ch == MY_CH);
			rl_q <= done_ev && ars_on;
			if (csr_we)
			begin
				en_q <= rf_wr.data[CSR_EN];
				ars_q <= rf_wr.data[CSR_ARS] && HAVE_ARS;
				pri_q <= rf_wr.data[CSR_PRI_HI:CSR_PRI_LO];
				imask_q <= rf_wr.data[CSR_IMASK_HI:CSR_IMASK_LO];
				done_q <= !rf_wr.data[CSR_EN];
				err_q <= 1'b0;
			end
			else
			begin
				if (done_we || err_ev)
					en_q <= 1'b0;
				if (done_we)
					done_q <= 1'b1;
				if (err_ev)
					err_q <= 1'b1;
			end
			// Sources stay until software reads the CSR
			if (done_we)
				isrc_q[IRQ_DONE] <= 1'b1;
			else if (csr_re)
				isrc_q[IRQ_DONE] <= 1'b0;
			if (err_ev)
				isrc_q[IRQ_ERR] <= 1'b1;
			else if (csr_re)
				isrc_q[IRQ_ERR] <= 1'b0;
		end
	end

	// Host writes win over engine write-back
	always_ff @(posedge clk)
	begin
		if (txsz_we)
			size_q <= rf_wr.data[11:0];
		else if (upd_me)
			size_q <= de_upd.size;
		else if (rl_q)
			size_q <= sh_size;
		if (adr0_we)
			src_q <= rf_wr.data;
		else if (upd_me)
			src_q <= de_upd.src;
		else if (rl_q)
			src_q <= sh_src;
		if (adr1_we)
			dst_q <= rf_wr.data;
		else if (upd_me)
			dst_q <= de_upd.dst;
		else if (rl_q)
			dst_q <= sh_dst;
	end

	if (HAVE_ARS)
	begin : g_shadow
		always_ff @(posedge clk)
		begin
			if (txsz_we)
				sh_size <= rf_wr.data[11:0];
			if (adr0_we)
				sh_src <= rf_wr.data;
			if (adr1_we)
				sh_dst <= rf_wr.data;
		end
	end
	else
	begin : g_no_shadow
		assign sh_size = '0;
		assign sh_src = '0;
		assign sh_dst = '0;
	end

	always_comb
	begin
		csr_word = '0;
		csr_word[CSR_EN] = en_q;
		csr_word[CSR_ARS] = ars_on;
		csr_word[CSR_BUSY] = busy_q;
		csr_word[CSR_DONE] = done_q;
		csr_word[CSR_ERR] = err_q;
		csr_word[CSR_PRI_HI:CSR_PRI_LO] = pri_q;
		csr_word[CSR_IMASK_HI:CSR_IMASK_LO] = imask_q;
		csr_word[CSR_ISRC_HI:CSR_ISRC_LO] = isrc_q;
	end

	always_comb
	begin
		rd_words[REG_CSR] = csr_word;
		rd_words[REG_TXSZ] = {20'b0, size_q};
		rd_words[REG_ADR0] = src_q;
		rd_words[REG_ADR1] = dst_q;
		regs.en = en_q && !done_q;
		regs.pri = pri_q;
		regs.src = src_q;
		regs.dst = dst_q;
		regs.size = size_q;
	end

	assign irq = |(isrc_q & imask_q);

	assert property (@(posedge clk) disable iff (!rst) !(done_ev && err_ev));

endmodule

//--- dma_ch_sel.sv
`timescale 1ns/1ps

module dma_ch_sel
	import dma_pkg::*;
(
	input logic clk,
	input logic rst,
	input ch_regs_t [NUM_CH-1:0] ch_regs,
	input de_stat_t de_stat,
	output logic start,
	output ch_t grant_ch,
	output ch_regs_t grant_regs
);

	typedef enum logic [1:0] {SEL_IDLE, SEL_HOLD, SEL_GAP} sel_state_t;

	sel_state_t state;
	logic req;
	ch_t pick;
	logic [2:0] best_pri;

	// Strict compare keeps the lower channel on a tie
	always_comb
	begin
		req = 1'b0;
		pick = '0;
		best_pri = '0;
		for (int i = 0; i < NUM_CH; i++)
		begin
			if (ch_regs[i].en && (!req || (ch_regs[i].pri > best_pri)))
			begin
				req = 1'b1;
				pick = CH_W'(i);
				best_pri = ch_regs[i].pri;
			end
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= SEL_IDLE;
			start <= 1'b0;
			grant_ch <= '0;
		end
		else
		begin
			start <= 1'b0;
			case (state)
				SEL_IDLE:
					if (req)
					begin
						start <= 1'b1;
						grant_ch <= pick;
						state <= SEL_HOLD;
					end
				SEL_HOLD:
					if (de_stat.done || de_stat.err)
						state <= SEL_GAP;
				default:
					state <= SEL_IDLE;
			endcase
		end
	end

	assign grant_regs = ch_regs[grant_ch];

	// Engine must be back in idle before a new grant starts
	assert property (@(posedge clk) disable iff (!rst) start |-> !de_stat.busy);

endmodule

//--- dma_engine.sv
`timescale 1ns/1ps

module dma_engine
	import dma_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input ch_t grant_ch,
	input ch_regs_t grant_regs,
	input logic [NUM_CH-1:0] stop,
	input mem_rsp_t mem_rsp,
	output mem_req_t mem_req,
	output de_upd_t de_upd,
	output de_stat_t de_stat
);

	typedef enum logic [1:0] {DE_IDLE, DE_READ, DE_WRITE, DE_UPDATE} de_state_t;

	de_state_t state;
	ch_t ch_q;
	logic upd_q;
	logic done_q;
	logic err_q;
	logic stop_q;
	logic stop_now;
	logic [31:0] src_q;
	logic [31:0] dst_q;
	logic [31:0] data_q;
	logic [11:0] cnt_q;

	// A stop during a pending request waits for that request to finish
	assign stop_now = stop_q || stop[ch_q];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= DE_IDLE;
			ch_q <= '0;
			upd_q <= 1'b0;
			done_q <= 1'b0;
			err_q <= 1'b0;
			stop_q <= 1'b0;
		end
		else
		begin
			upd_q <= 1'b0;
			done_q <= 1'b0;
			err_q <= 1'b0;
			if ((state != DE_IDLE) && stop[ch_q])
				stop_q <= 1'b1;
			case (state)
				DE_IDLE:
					if (start)
					begin
						ch_q <= grant_ch;
						stop_q <= 1'b0;
						if (grant_regs.size == '0)
							done_q <= 1'b1;
						else
							state <= DE_READ;
					end
				DE_READ:
					if (mem_rsp.ready)
					begin
						if (mem_rsp.err || stop_now)
						begin
							err_q <= 1'b1;
							state <= DE_IDLE;
						end
						else
							state <= DE_WRITE;
					end
				DE_WRITE:
					if (mem_rsp.ready)
					begin
						if (mem_rsp.err)
						begin
							err_q <= 1'b1;
							state <= DE_IDLE;
						end
						else
						begin
							upd_q <= 1'b1;
							state <= DE_UPDATE;
							if (stop_now)
								err_q <= 1'b1;
							else if (cnt_q == 12'd1)
								done_q <= 1'b1;
						end
					end
				DE_UPDATE:
					if (done_q || err_q)
						state <= DE_IDLE;
					else
						state <= DE_READ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == DE_IDLE) && start)
		begin
			src_q <= grant_regs.src;
			dst_q <= grant_regs.dst;
			cnt_q <= grant_regs.size;
		end
		if ((state == DE_READ) && mem_rsp.ready)
			data_q <= mem_rsp.rdata;
		if ((state == DE_WRITE) && mem_rsp.ready && !mem_rsp.err)
		begin
			src_q <= src_q + 32'd4;
			dst_q <= dst_q + 32'd4;
			cnt_q <= cnt_q - 12'd1;
		end
	end

	always_comb
	begin
		mem_req.valid = (state == DE_READ) || (state == DE_WRITE);
		mem_req.we = (state == DE_WRITE);
		mem_req.addr = (state == DE_WRITE) ? dst_q[31:2] : src_q[31:2];
		mem_req.wdata = data_q;
		// Working copies are already advanced when upd_q is high
		de_upd.upd = upd_q;
		de_upd.ch = ch_q;
		de_upd.src = src_q;
		de_upd.dst = dst_q;
		de_upd.size = cnt_q;
		de_stat.busy = (state != DE_IDLE);
		de_stat.done = done_q;
		de_stat.err = err_q;
		de_stat.ch = ch_q;
	end

	assert property (@(posedge clk) disable iff (!rst)
		mem_req.valid && !mem_rsp.ready |=> mem_req.valid && $stable(mem_req));

endmodule

//--- dma_pkg.sv
package dma_pkg;

	localparam int NUM_CH = 2;
	localparam int CH_W = $clog2(NUM_CH);

	typedef logic [CH_W-1:0] ch_t;

	// Word offsets inside a channel block
	localparam logic [1:0] REG_CSR = 2'd0;
	localparam logic [1:0] REG_TXSZ = 2'd1;
	localparam logic [1:0] REG_ADR0 = 2'd2;
	localparam logic [1:0] REG_ADR1 = 2'd3;

	// CSR bit positions
	localparam int CSR_EN = 0;
	localparam int CSR_ARS = 1;
	localparam int CSR_STOP = 3;
	localparam int CSR_BUSY = 10;
	localparam int CSR_DONE = 11;
	localparam int CSR_ERR = 12;
	localparam int CSR_PRI_LO = 13;
	localparam int CSR_PRI_HI = 15;
	localparam int CSR_IMASK_LO = 17;
	localparam int CSR_IMASK_HI = 18;
	localparam int CSR_ISRC_LO = 20;
	localparam int CSR_ISRC_HI = 21;

	// Bit order inside the mask and source fields
	localparam int IRQ_DONE = 0;
	localparam int IRQ_ERR = 1;

	typedef struct packed {
		logic we;
		ch_t ch;
		logic [1:0] idx;
		logic [31:0] data;
	} rf_wr_t;

	typedef struct packed {
		logic re;
		ch_t ch;
		logic [1:0] idx;
	} rf_rd_t;

	typedef struct packed {
		logic en;
		logic [2:0] pri;
		logic [31:0] src;
		logic [31:0] dst;
		logic [11:0] size;
	} ch_regs_t;

	typedef struct packed {
		logic upd;
		ch_t ch;
		logic [31:0] src;
		logic [31:0] dst;
		logic [11:0] size;
	} de_upd_t;

	typedef struct packed {
		logic busy;
		logic done;
		logic err;
		ch_t ch;
	} de_stat_t;

	typedef struct packed {
		logic valid;
		logic we;
		logic [29:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
		logic err;
	} mem_rsp_t;

endpackage

//--- dma_top.sv
`timescale 1ns/1ps

module dma_top
	import dma_pkg::*;
#(
	parameter bit [NUM_CH-1:0] HAVE_ARS = 2'b01
)
(
	input logic clk,
	input logic rst,
	input logic [31:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [31:0] s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [31:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp,
	output logic irq
);

	rf_wr_t rf_wr;
	rf_rd_t rf_rd;
	logic [NUM_CH-1:0][3:0][31:0] rd_data;
	logic [NUM_CH-1:0] irq_ch;
	logic [NUM_CH-1:0] stop_ch;
	ch_regs_t [NUM_CH-1:0] ch_regs;
	de_upd_t de_upd;
	de_stat_t de_stat;
	logic start;
	ch_t grant_ch;
	ch_regs_t grant_regs;

	dma_axil_slave u_slave (
		.clk(clk),
		.rst(rst),
		.s_awaddr(s_awaddr),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_wdata(s_wdata),
		.s_wstrb(s_wstrb),
		.s_wvalid(s_wvalid),
		.s_wready(s_wready),
		.s_bresp(s_bresp),
		.s_bvalid(s_bvalid),
		.s_bready(s_bready),
		.s_araddr(s_araddr),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rresp(s_rresp),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready),
		.rf_wr(rf_wr),
		.rf_rd(rf_rd),
		.rd_data(rd_data),
		.irq_stat(irq_ch)
	);

	for (genvar i = 0; i < NUM_CH; i++)
	begin : g_ch
		dma_ch_rf #(
			.CH_NO(i),
			.HAVE_ARS(HAVE_ARS[i])
		) u_rf (
			.clk(clk),
			.rst(rst),
			.rf_wr(rf_wr),
			.rf_rd(rf_rd),
			.de_upd(de_upd),
			.de_stat(de_stat),
			.regs(ch_regs[i]),
			.rd_words(rd_data[i]),
			.stop(stop_ch[i]),
			.irq(irq_ch[i])
		);
	end

	dma_ch_sel u_sel (
		.clk(clk),
		.rst(rst),
		.ch_regs(ch_regs),
		.de_stat(de_stat),
		.start(start),
		.grant_ch(grant_ch),
		.grant_regs(grant_regs)
	);

	dma_engine u_engine (
		.clk(clk),
		.rst(rst),
		.start(start),
		.grant_ch(grant_ch),
		.grant_regs(grant_regs),
		.stop(stop_ch),
		.mem_rsp(mem_rsp),
		.mem_req(mem_req),
		.de_upd(de_upd),
		.de_stat(de_stat)
	);

	assign irq = |irq_ch;

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the testbench with the DUT, then run it
verilator --binary --timing --assert -j 0 \
	--top-module tb_dma_top \
	-f sim.f \
	-o tb_dma_top

./obj_dir/tb_dma_top

//--- sim.f
dma_pkg.sv
dma_axil_slave.sv
dma_ch_rf.sv
dma_ch_sel.sv
dma_engine.sv
dma_top.sv
tb_dma_top.sv

//--- tb_dma_top.sv
`timescale 1ns/1ps

module tb_dma_top
	import dma_pkg::*;
();

	// About 50 words at 12 cycles each plus bus traffic, with a wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	typedef struct packed {
		logic [29:0] addr;
		logic [31:0] data;
	} wr_ev_t;

	typedef struct packed {
		logic [31:0] src;
		logic [31:0] dst;
		logic [31:0] size;
	} ref_res_t;

	logic clk;
	logic rst;
	logic [31:0] s_awaddr;
	logic s_awvalid;
	logic s_awready;
	logic [31:0] s_wdata;
	logic [3:0] s_wstrb;
	logic s_wvalid;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready;
	logic [31:0] s_araddr;
	logic s_arvalid;
	logic s_arready;
	logic [31:0] s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	logic irq;

	logic [31:0] mem [1024];
	logic [31:0] exp_mem [1024];
	logic [31:0] lfsr_q;
	wr_ev_t exp_q[$];
	wr_ev_t got_q[$];
	logic [29:0] acc_log[$];
	wr_ev_t wr_ev;
	wr_ev_t got_ev;
	wr_ev_t want_ev;
	logic mem_hold;
	logic err_on;
	logic [29:0] err_addr;
	logic pend;
	int dly;
	int wr_cnt;
	int cycles;

	dma_top #(
		.HAVE_ARS(2'b01)
	) UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("ERROR time=%0t %s", $time, why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			$display("MISMATCH time=%0t %s got=%08h exp=%08h", $time, name, got, want);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] reg_addr(input int ch, input logic [1:0] idx);
		return 32'(32 * (ch + 1)) + 32'(idx) * 32'd4;
	endfunction

	function automatic logic [31:0] csr_bits(input logic en, input logic ars, input logic stop,
		input logic [2:0] pri, input logic [1:0] imask, input logic done, input logic err,
		input logic [1:0] isrc);
		logic [31:0] v;
		v = '0;
		v[CSR_EN] = en;
		v[CSR_ARS] = ars;
		v[CSR_STOP] = stop;
		v[CSR_DONE] = done;
		v[CSR_ERR] = err;
		v[CSR_PRI_HI:CSR_PRI_LO] = pri;
		v[CSR_IMASK_HI:CSR_IMASK_LO] = imask;
		v[CSR_ISRC_HI:CSR_ISRC_LO] = isrc;
		return v;
	endfunction

	// Expected copy of n words; updates the expected image and write order
	function automatic ref_res_t predict_copy(input logic [31:0] src, input logic [31:0] dst,
		input int size, input int n);
		ref_res_t r;
		wr_ev_t ev;
		for (int i = 0; i < n; i++)
		begin
			ev.addr = 30'((dst >> 2) + 32'(i));
			ev.data = exp_mem[10'((src >> 2) + 32'(i))];
			exp_mem[ev.addr[9:0]] = ev.data;
			exp_q.push_back(ev);
		end
		r.src = src + 32'(4 * n);
		r.dst = dst + 32'(4 * n);
		r.size = 32'(size - n);
		return r;
	endfunction

	function automatic logic in_range(input logic [29:0] a, input logic [31:0] base, input int n);
		return ({a, 2'b00} >= base) && ({a, 2'b00} < base + 32'(4 * n));
	endfunction

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		s_awaddr <= addr;
		s_awvalid <= 1'b1;
		s_wdata <= data;
		s_wstrb <= 4'hf;
		s_wvalid <= 1'b1;
		s_bready <= 1'b1;
		@(posedge clk);
		while (!(s_awready && s_wready))
			@(posedge clk);
		s_awvalid <= 1'b0;
		s_wvalid <= 1'b0;
		while (!s_bvalid)
			@(posedge clk);
		check("s_bresp", 32'(s_bresp), 32'd0);
		s_bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clk);
		s_araddr <= addr;
		s_arvalid <= 1'b1;
		s_rready <= 1'b1;
		@(posedge clk);
		while (!s_arready)
			@(posedge clk);
		s_arvalid <= 1'b0;
		while (!s_rvalid)
			@(posedge clk);
		check("s_rresp", 32'(s_rresp), 32'd0);
		data = s_rdata;
		s_rready <= 1'b0;
	endtask

	task automatic read_check(input string name, input logic [31:0] addr,
		input logic [31:0] want);
		logic [31:0] got;
		axi_read(addr, got);
		check(name, got, want);
	endtask

	task automatic setup_ch(input int ch, input logic [31:0] src, input logic [31:0] dst,
		input logic [31:0] size);
		axi_write(reg_addr(ch, REG_TXSZ), size);
		axi_write(reg_addr(ch, REG_ADR0), src);
		axi_write(reg_addr(ch, REG_ADR1), dst);
	endtask

	task automatic wait_irq();
		while (!irq)
			@(posedge clk);
	endtask

	task automatic check_image();
		for (int i = 0; i < 1024; i++)
			check($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);
		check("pending expected writes", 32'(exp_q.size()), 32'd0);
	endtask

	// Memory model, 0 to 3 extra wait cycles per request
	always @(posedge clk)
	begin
		if (mem_rsp.ready)
			mem_rsp <= '0;
		else if (mem_req.valid && !mem_hold)
		begin
			if (!pend)
			begin
				pend = 1'b1;
				dly = take_bits(2);
			end
			if (dly == 0)
			begin
				pend = 1'b0;
				acc_log.push_back(mem_req.addr);
				mem_rsp.ready <= 1'b1;
				mem_rsp.err <= 1'b0;
				mem_rsp.rdata <= '0;
				if (err_on && (mem_req.addr == err_addr))
					mem_rsp.err <= 1'b1;
				else if (mem_req.we)
				begin
					mem[mem_req.addr[9:0]] = mem_req.wdata;
					wr_ev.addr = mem_req.addr;
					wr_ev.data = mem_req.wdata;
					got_q.push_back(wr_ev);
					wr_cnt++;
				end
				else
					mem_rsp.rdata <= mem[mem_req.addr[9:0]];
			end
			else
				dly = dly - 1;
		end
	end

	// Every completed write against the expected order
	always @(negedge clk)
	begin
		while (got_q.size() > 0)
		begin
			got_ev = got_q.pop_front();
			if (exp_q.size() == 0)
				abort_run($sformatf("unexpected memory write to word %0h", got_ev.addr));
			else
			begin
				want_ev = exp_q.pop_front();
				check("mem write addr", 32'(got_ev.addr), 32'(want_ev.addr));
				check("mem write data", got_ev.data, want_ev.data);
			end
		end
	end

	initial
	begin
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
				abort_run($sformatf("timeout, no end of the run after %0d cycles", cycles));
		end
	end

	initial
	begin
		logic [31:0] rd;
		logic [31:0] want;
		ref_res_t r;
		ref_res_t r1;
		int base;
		int n;
		int k;
		int last1;
		int first0;

		rst <= 1'b0;
		s_awaddr <= '0;
		s_awvalid <= 1'b0;
		s_wdata <= '0;
		s_wstrb <= '0;
		s_wvalid <= 1'b0;
		s_bready <= 1'b0;
		s_araddr <= '0;
		s_arvalid <= 1'b0;
		s_rready <= 1'b0;
		mem_rsp <= '0;
		mem_hold = 1'b0;
		err_on = 1'b0;
		err_addr = '0;
		pend = 1'b0;
		dly = 0;
		wr_cnt = 0;
		lfsr_q = 32'h06d0baf9;
		for (int i = 0; i < 1024; i++)
		begin
			mem[i] = take_bits(32);
			exp_mem[i] = mem[i];
		end
		repeat (8) @(posedge clk);
		rst <= 1'b1;

		// Reset values and plain register access
		read_check("ch0 CSR", reg_addr(0, REG_CSR), 32'd0);
		read_check("ch1 CSR", reg_addr(1, REG_CSR), 32'd0);
		read_check("global status", 32'd0, 32'd0);
		check("irq", 32'(irq), 32'd0);
		setup_ch(0, 32'h1234_5678, 32'h9abc_def0, 32'h0000_0a5c);
		read_check("ch0 TXSZ", reg_addr(0, REG_TXSZ), 32'h0000_0a5c);
		read_check("ch0 ADR0", reg_addr(0, REG_ADR0), 32'h1234_5678);
		read_check("ch0 ADR1", reg_addr(0, REG_ADR1), 32'h9abc_def0);

		// Channel 1, 16 words, done interrupt
		setup_ch(1, 32'h100, 32'h400, 32'd16);
		r = predict_copy(32'h100, 32'h400, 16, 16);
		axi_write(reg_addr(1, REG_CSR), csr_bits(1, 0, 0, 3'd0, 2'b01, 0, 0, 2'b00));
		wait_irq();
		read_check("ch1 CSR", reg_addr(1, REG_CSR), csr_bits(0, 0, 0, 3'd0, 2'b01, 1, 0, 2'b01));
		read_check("ch1 TXSZ", reg_addr(1, REG_TXSZ), r.size);
		read_check("ch1 ADR0", reg_addr(1, REG_ADR0), r.src);
		read_check("ch1 ADR1", reg_addr(1, REG_ADR1), r.dst);
		read_check("ch1 CSR", reg_addr(1, REG_CSR), csr_bits(0, 0, 0, 3'd0, 2'b01, 1, 0, 2'b00));
		check("irq", 32'(irq), 32'd0);
		check_image();

		// Two channels, channel 1 at the higher priority
		acc_log.delete();
		setup_ch(0, 32'h280, 32'h700, 32'd8);
		setup_ch(1, 32'h200, 32'h600, 32'd8);
		r1 = predict_copy(32'h200, 32'h600, 8, 8);
		r = predict_copy(32'h280, 32'h700, 8, 8);
		axi_write(reg_addr(1, REG_CSR), csr_bits(1, 0, 0, 3'd3, 2'b01, 0, 0, 2'b00));
		axi_write(reg_addr(0, REG_CSR), csr_bits(1, 0, 0, 3'd1, 2'b01, 0, 0, 2'b00));
		do
			axi_read(32'd0, rd);
		while (rd != 32'd3);
		read_check("ch1 CSR", reg_addr(1, REG_CSR), csr_bits(0, 0, 0, 3'd3, 2'b01, 1, 0, 2'b01));
		read_check("ch0 CSR", reg_addr(0, REG_CSR), csr_bits(0, 0, 0, 3'd1, 2'b01, 1, 0, 2'b01));
		read_check("ch1 ADR1", reg_addr(1, REG_ADR1), r1.dst);
		read_check("ch0 ADR1", reg_addr(0, REG_ADR1), r.dst);
		check("access count", 32'(acc_log.size()), 32'd32);
		last1 = -1;
		first0 = acc_log.size();
		foreach (acc_log[i])
		begin
			if (in_range(acc_log[i], 32'h200, 8) || in_range(acc_log[i], 32'h600, 8))
				last1 = i;
			if ((in_range(acc_log[i], 32'h280, 8) || in_range(acc_log[i], 32'h700, 8))
				&& (first0 > i))
				first0 = i;
		end
		if (first0 < last1)
			abort_run("channel 0 reached memory before channel 1 had finished");
		check("irq", 32'(irq), 32'd0);
		check_image();

		// Memory error on the fifth source word
		base = wr_cnt;
		err_addr = 30'((32'h300 >> 2) + 32'd4);
		err_on = 1'b1;
		setup_ch(1, 32'h300, 32'h800, 32'd8);
		r = predict_copy(32'h300, 32'h800, 8, 4);
		axi_write(reg_addr(1, REG_CSR), csr_bits(1, 0, 0, 3'd2, 2'b10, 0, 0, 2'b00));
		wait_irq();
		read_check("ch1 CSR", reg_addr(1, REG_CSR), csr_bits(0, 0, 0, 3'd2, 2'b10, 0, 1, 2'b10));
		read_check("ch1 TXSZ", reg_addr(1, REG_TXSZ), r.size);
		read_check("ch1 ADR0", reg_addr(1, REG_ADR0), r.src);
		read_check("ch1 ADR1", reg_addr(1, REG_ADR1), r.dst);
		check("ch1 words written", 32'(wr_cnt - base), 32'd4);
		check("irq", 32'(irq), 32'd0);
		err_on = 1'b0;
		check_image();

		// Channel 0 with auto restart, then a stop
		base = wr_cnt;
		setup_ch(0, 32'h380, 32'h900, 32'd4);
		for (int p = 0; p < 4; p++)
			r = predict_copy(32'h380, 32'h900, 4, 4);
		axi_write(reg_addr(0, REG_CSR), csr_bits(1, 1, 0, 3'd0, 2'b10, 0, 0, 2'b00));
		while (wr_cnt - base < 8)
			@(negedge clk);
		mem_hold = 1'b1;
		@(posedge clk);
		while (!(mem_req.valid && !mem_rsp.ready))
			@(posedge clk);
		axi_write(reg_addr(0, REG_CSR), csr_bits(1, 1, 1, 3'd0, 2'b10, 0, 0, 2'b00));
		repeat (2) @(posedge clk);
		@(negedge clk);
		mem_hold = 1'b0;
		wait_irq();
		read_check("ch0 CSR", reg_addr(0, REG_CSR), csr_bits(0, 1, 0, 3'd0, 2'b10, 0, 1, 2'b10));
		n = wr_cnt - base;
		if ((n < 8) || (n > 16))
			abort_run($sformatf("auto restart wrote %0d words, not two or more passes", n));
		k = n % 4;
		axi_read(reg_addr(0, REG_ADR0), rd);
		want = 32'h380 + 32'(4 * k);
		// Stop on the last write of a pass leaves the advanced address
		if ((k == 0) && (rd == 32'h390))
			want = 32'h390;
		check("ch0 ADR0 after stop", rd, want);
		exp_q.delete();
		check_image();

		$display("=== PASS ===");
		$finish;
	end

endmodule
